// ==== Bender.yml ====
package:
  name: i2c_master

sources:
  - files:
      - rtl/i2c_pkg.sv
      - rtl/i2c_scl_gen.sv
      - rtl/i2c_line_sync.sv
      - rtl/i2c_byte_engine.sv
      - rtl/i2c_master_fsm.sv
      - rtl/i2c_master.sv
  - target: simulation
    files:
      - testbench/i2c_slave_model.sv
      - testbench/tb_i2c_master.sv

// ==== i2c_master.f ====
rtl/i2c_pkg.sv
rtl/i2c_scl_gen.sv
rtl/i2c_line_sync.sv
rtl/i2c_byte_engine.sv
rtl/i2c_master_fsm.sv
rtl/i2c_master.sv
testbench/i2c_slave_model.sv
testbench/tb_i2c_master.sv

// ==== rtl/i2c_byte_engine.sv ====
`timescale 1ns/100ps
module i2c_byte_engine (
    input  logic               i_clk,
    input  logic               reset_n,
    input  i2c_pkg::byte_op_e  op_i,
    input  logic               op_start_i,
    input  i2c_pkg::byte_t     tx_byte_i,
    input  logic               ack_bit_i,
    input  logic               scl_rise_i,
    input  logic               scl_fall_i,
    input  logic               start_point_i,
    input  logic               hold_point_i,
    input  logic               sda_in_i,
    output logic               sda_drive_low_o,
    output logic               done_o,
    output logic               rx_nack_o,
    output i2c_pkg::byte_t     rx_byte_o
);
    import i2c_pkg::*;

    byte_op_e   op_q;
    byte_t      shreg;          // tx bits leave at bit 7, rx bits enter at bit 0
    logic [3:0] bit_cnt;        // 0..8 data bits, 9 is the ack slot
    logic       active;
    logic       ack_q;          // 1 sends a nack
    logic       arm_rise;
    logic       arm_fall;

    always_ff @(posedge i_clk or negedge reset_n) begin
        if (!reset_n) begin
            op_q            <= OP_NONE;
            shreg           <= '0;
            bit_cnt         <= '0;
            active          <= 1'b0;
            ack_q           <= 1'b0;
            arm_rise        <= 1'b0;
            arm_fall        <= 1'b0;
            sda_drive_low_o <= 1'b0;
            done_o          <= 1'b0;
            rx_nack_o       <= 1'b0;
            rx_byte_o       <= '0;
        end else begin
            done_o <= 1'b0;
            // an scl edge arms, the next matching strobe consumes it
            if (scl_rise_i) arm_rise <= 1'b1;
            else if (start_point_i) arm_rise <= 1'b0;
            if (scl_fall_i) arm_fall <= 1'b1;
            else if (hold_point_i) arm_fall <= 1'b0;

            if (op_start_i) begin
                op_q            <= op_i;
                active          <= (op_i != OP_NONE);
                shreg           <= tx_byte_i;
                ack_q           <= ack_bit_i;
                bit_cnt         <= '0;
                arm_rise        <= 1'b0;    // edges of the current half period don't count
                arm_fall        <= 1'b0;
                sda_drive_low_o <= 1'b0;
            end else if (active && op_q == OP_TX_BYTE) begin
                if (hold_point_i && arm_fall && bit_cnt < 4'd8) begin
                    sda_drive_low_o <= ~shreg[7];           // msb first
                    shreg           <= {shreg[6:0], 1'b0};
                    bit_cnt         <= bit_cnt + 4'd1;
                end else if (hold_point_i && arm_fall && bit_cnt == 4'd8) begin
                    sda_drive_low_o <= 1'b0;                // let the slave ack
                    bit_cnt         <= 4'd9;
                end
                if (start_point_i && arm_rise && bit_cnt == 4'd9) begin
                    rx_nack_o <= sda_in_i;                  // high on the ninth clock is a nack
                    done_o    <= 1'b1;
                    active    <= 1'b0;
                end
            end else if (active && op_q == OP_RX_BYTE) begin
                if (start_point_i && arm_rise && bit_cnt < 4'd8) begin
                    shreg   <= {shreg[6:0], sda_in_i};
                    bit_cnt <= bit_cnt + 4'd1;
                end
                if (hold_point_i && arm_fall && bit_cnt == 4'd8) begin
                    sda_drive_low_o <= ~ack_q;
                    bit_cnt         <= 4'd9;
                end else if (hold_point_i && arm_fall && bit_cnt == 4'd9) begin
                    // ack clock is over, sda free again while scl is low
                    sda_drive_low_o <= 1'b0;
                    rx_byte_o       <= shreg;
                    rx_nack_o       <= 1'b0;
                    done_o          <= 1'b1;
                    active          <= 1'b0;
                end
            end
        end
    end

endmodule

// ==== rtl/i2c_line_sync.sv ====
`timescale 1ns/100ps
module i2c_line_sync (
    input  logic i_clk,
    input  logic reset_n,
    input  logic scl_en_i,
    input  logic scl_i,
    input  logic sda_drive_low_i,
    output logic scl_rise_o,
    output logic scl_fall_o,
    output logic scl_high_o,
    output logic sda_in_o,
    inout  wire  scl_pad_o,
    inout  wire  sda_pad_o
);

    logic scl_curr;
    logic scl_prev;
    logic sda_meta;

    // sampled on the falling edge so the edge pulses settle before the next rising edge
    always_ff @(negedge i_clk or negedge reset_n) begin
        if (!reset_n) begin
            scl_curr <= 1'b1;           // bus idles high
            scl_prev <= 1'b1;
            sda_meta <= 1'b1;
            sda_in_o <= 1'b1;
        end else begin
            scl_curr <= scl_i;
            scl_prev <= scl_curr;
            sda_meta <= sda_pad_o;      // slave drives sda asynchronously, two stage sync
            sda_in_o <= sda_meta;
        end
    end

    assign scl_rise_o = scl_curr & ~scl_prev;
    assign scl_fall_o = ~scl_curr & scl_prev;
    assign scl_high_o = scl_curr & scl_prev;       // settled high, not the edge cycle

    // open drain, pull-ups give the high level
    assign scl_pad_o = (scl_en_i && !scl_i) ? 1'b0 : 1'bz;
    assign sda_pad_o = sda_drive_low_i ? 1'b0 : 1'bz;

endmodule

// ==== rtl/i2c_master.sv ====
`timescale 1ns/100ps
module i2c_master (
    input  logic                  i_clk,
    input  logic                  reset_n,
    input  logic                  req_trans_i,
    input  i2c_pkg::byte_t        addr_rw_i,
    input  i2c_pkg::sub_addr_t    sub_addr_i,
    input  logic                  sub_len_i,
    input  i2c_pkg::byte_count_t  byte_len_i,
    input  i2c_pkg::byte_t        data_write_i,
    output i2c_pkg::byte_t        data_out_o,
    output logic                  valid_out_o,
    output logic                  req_data_chunk_o,
    output logic                  busy_o,
    output logic                  nack_o,
    inout  wire                   scl_o,
    inout  wire                   sda_o
);
    import i2c_pkg::*;

    logic     scl_en, scl_int;
    logic     start_point, hold_point, stop_point, release_point;
    logic     scl_rise, scl_fall, scl_high, sda_in;
    logic     eng_sda_low, fsm_sda_low, sda_low;
    logic     eng_start, eng_ack_bit, eng_done, eng_nack;
    byte_op_e eng_op;
    byte_t    eng_tx_byte, eng_rx_byte;

    assign sda_low = eng_sda_low | fsm_sda_low;    // bit data or start/stop framing

    i2c_scl_gen u_scl_gen (
        .i_clk(i_clk), .reset_n(reset_n), .scl_en_i(scl_en), .scl_o(scl_int), .phase_o(),
        .start_point_o(start_point), .hold_point_o(hold_point),
        .stop_point_o(stop_point), .release_point_o(release_point)
    );

    i2c_line_sync u_line_sync (
        .i_clk(i_clk), .reset_n(reset_n), .scl_en_i(scl_en), .scl_i(scl_int),
        .sda_drive_low_i(sda_low), .scl_rise_o(scl_rise), .scl_fall_o(scl_fall),
        .scl_high_o(scl_high), .sda_in_o(sda_in), .scl_pad_o(scl_o), .sda_pad_o(sda_o)
    );

    i2c_byte_engine u_byte_engine (
        .i_clk(i_clk), .reset_n(reset_n), .op_i(eng_op), .op_start_i(eng_start),
        .tx_byte_i(eng_tx_byte), .ack_bit_i(eng_ack_bit), .scl_rise_i(scl_rise),
        .scl_fall_i(scl_fall), .start_point_i(start_point), .hold_point_i(hold_point),
        .sda_in_i(sda_in), .sda_drive_low_o(eng_sda_low), .done_o(eng_done),
        .rx_nack_o(eng_nack), .rx_byte_o(eng_rx_byte)
    );

    i2c_master_fsm u_fsm (
        .i_clk(i_clk), .reset_n(reset_n), .req_trans_i(req_trans_i), .addr_rw_i(addr_rw_i),
        .sub_addr_i(sub_addr_i), .sub_len_i(sub_len_i), .byte_len_i(byte_len_i),
        .data_write_i(data_write_i), .scl_rise_i(scl_rise), .scl_fall_i(scl_fall),
        .scl_high_i(scl_high), .start_point_i(start_point), .stop_point_i(stop_point),
        .release_point_i(release_point), .eng_done_i(eng_done), .eng_nack_i(eng_nack),
        .eng_rx_byte_i(eng_rx_byte), .scl_en_o(scl_en), .fsm_sda_low_o(fsm_sda_low),
        .eng_op_o(eng_op), .eng_start_o(eng_start), .eng_tx_byte_o(eng_tx_byte),
        .eng_ack_bit_o(eng_ack_bit), .data_out_o(data_out_o), .valid_out_o(valid_out_o),
        .req_data_chunk_o(req_data_chunk_o), .busy_o(busy_o), .nack_o(nack_o)
    );

endmodule

// ==== rtl/i2c_master_fsm.sv ====
`timescale 1ns/100ps
module i2c_master_fsm (
    input  logic                  i_clk,
    input  logic                  reset_n,
    input  logic                  req_trans_i,
    input  i2c_pkg::byte_t        addr_rw_i,
    input  i2c_pkg::sub_addr_t    sub_addr_i,
    input  logic                  sub_len_i,
    input  i2c_pkg::byte_count_t  byte_len_i,
    input  i2c_pkg::byte_t        data_write_i,
    input  logic                  scl_rise_i,
    input  logic                  scl_fall_i,
    input  logic                  scl_high_i,
    input  logic                  start_point_i,
    input  logic                  stop_point_i,
    input  logic                  release_point_i,
    input  logic                  eng_done_i,
    input  logic                  eng_nack_i,
    input  i2c_pkg::byte_t        eng_rx_byte_i,
    output logic                  scl_en_o,
    output logic                  fsm_sda_low_o,
    output i2c_pkg::byte_op_e     eng_op_o,
    output logic                  eng_start_o,
    output i2c_pkg::byte_t        eng_tx_byte_o,
    output logic                  eng_ack_bit_o,
    output i2c_pkg::byte_t        data_out_o,
    output logic                  valid_out_o,
    output logic                  req_data_chunk_o,
    output logic                  busy_o,
    output logic                  nack_o
);
    import i2c_pkg::*;

    i2c_state_e  state;
    byte_t       addr_q;        // bit 0 is r/w, 1 = read
    sub_addr_t   sub_addr_q;
    logic        sub_len_q;     // 1 = 16 bit sub-address
    byte_t       data_q;        // first write byte comes with the request
    byte_count_t bytes_left;    // includes the byte in flight
    logic        read_phase;    // second address byte after the repeated start
    logic        grab_wait;

    task automatic issue(input byte_op_e op, input byte_t tx, input logic ack);
        eng_op_o      <= op;
        eng_tx_byte_o <= tx;
        eng_ack_bit_o <= ack;
        eng_start_o   <= 1'b1;
    endtask

    // slave nack, drop the bus without a stop
    task automatic abort();
        nack_o        <= 1'b1;
        busy_o        <= 1'b0;
        scl_en_o      <= 1'b0;
        fsm_sda_low_o <= 1'b0;
        state         <= IDLE;
    endtask

    always_ff @(posedge i_clk or negedge reset_n) begin
        if (!reset_n) begin
            state            <= IDLE;
            addr_q           <= '0;
            sub_addr_q       <= '0;
            sub_len_q        <= 1'b0;
            data_q           <= '0;
            bytes_left       <= '0;
            read_phase       <= 1'b0;
            grab_wait        <= 1'b0;
            scl_en_o         <= 1'b0;
            fsm_sda_low_o    <= 1'b0;
            eng_op_o         <= OP_NONE;
            eng_start_o      <= 1'b0;
            eng_tx_byte_o    <= '0;
            eng_ack_bit_o    <= 1'b0;
            data_out_o       <= '0;
            valid_out_o      <= 1'b0;
            req_data_chunk_o <= 1'b0;
            busy_o           <= 1'b0;
            nack_o           <= 1'b0;
        end else begin
            eng_start_o      <= 1'b0;
            valid_out_o      <= 1'b0;
            req_data_chunk_o <= 1'b0;
            case (state)
                IDLE: begin
                    if (req_trans_i) begin
                        addr_q     <= addr_rw_i;
                        sub_addr_q <= sub_addr_i;
                        sub_len_q  <= sub_len_i;
                        data_q     <= data_write_i;
                        bytes_left <= byte_len_i;
                        read_phase <= 1'b0;
                        nack_o     <= 1'b0;         // cleared by the next accepted request
                        busy_o     <= 1'b1;
                        scl_en_o   <= 1'b1;         // scl starts high, start comes first
                        state      <= START;
                    end
                end
                START, RESTART: begin
                    // sda falls while scl is high, address follows with the r/w bit
                    if (start_point_i && scl_high_i) begin
                        fsm_sda_low_o <= 1'b1;
                        issue(OP_TX_BYTE, {addr_q[7:1], state == RESTART}, 1'b0);
                        read_phase    <= (state == RESTART);
                        state         <= SLAVE_ADDR;
                    end
                end
                SLAVE_ADDR: begin
                    if (scl_fall_i) fsm_sda_low_o <= 1'b0;     // engine owns sda from here
                    if (eng_done_i) begin
                        if (eng_nack_i) begin
                            abort();
                        end else if (read_phase) begin
                            issue(OP_RX_BYTE, '0, bytes_left == 8'd1);
                            state <= READ_DATA;
                        end else if (sub_len_q) begin
                            issue(OP_TX_BYTE, sub_addr_q[15:8], 1'b0);
                            state <= SUB_ADDR_HI;
                        end else begin
                            issue(OP_TX_BYTE, sub_addr_q[7:0], 1'b0);
                            state <= SUB_ADDR_LO;
                        end
                    end
                end
                SUB_ADDR_HI: begin
                    if (eng_done_i && eng_nack_i) begin
                        abort();
                    end else if (eng_done_i) begin
                        issue(OP_TX_BYTE, sub_addr_q[7:0], 1'b0);
                        state <= SUB_ADDR_LO;
                    end
                end
                SUB_ADDR_LO: begin
                    if (eng_done_i && eng_nack_i) begin
                        abort();
                    end else if (eng_done_i && addr_q[0]) begin
                        state <= RESTART;
                    end else if (eng_done_i) begin
                        issue(OP_TX_BYTE, data_q, 1'b0);
                        state <= WRITE_DATA;
                    end
                end
                WRITE_DATA: begin
                    if (eng_done_i && eng_nack_i) begin
                        abort();
                    end else if (eng_done_i) begin
                        bytes_left <= bytes_left - 8'd1;
                        if (bytes_left == 8'd1) begin
                            state <= STOP;
                        end else begin
                            req_data_chunk_o <= 1'b1;   // host puts the next byte up
                            grab_wait        <= 1'b1;
                            state            <= GRAB_DATA;
                        end
                    end
                end
                GRAB_DATA: begin
                    if (grab_wait) begin
                        grab_wait <= 1'b0;
                    end else begin
                        issue(OP_TX_BYTE, data_write_i, 1'b0);
                        state <= WRITE_DATA;
                    end
                end
                READ_DATA: begin
                    if (eng_done_i) begin
                        data_out_o  <= eng_rx_byte_i;
                        valid_out_o <= 1'b1;
                        bytes_left  <= bytes_left - 8'd1;
                        if (bytes_left == 8'd1) begin
                            state <= STOP;
                        end else begin
                            issue(OP_RX_BYTE, '0, bytes_left == 8'd2);  // nack the last
                        end
                    end
                end
                STOP: begin
                    // pull sda low during scl low, then release it while scl is high
                    if (!fsm_sda_low_o) begin
                        if (!scl_high_i && !scl_rise_i) fsm_sda_low_o <= 1'b1;
                    end else if (stop_point_i && scl_high_i) begin
                        fsm_sda_low_o <= 1'b0;
                        state         <= RELEASE_BUS;
                    end
                end
                RELEASE_BUS: begin
                    if (release_point_i && scl_high_i) begin
                        scl_en_o <= 1'b0;               // scl parks high
                        busy_o   <= 1'b0;
                        state    <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// ==== rtl/i2c_pkg.sv ====
package i2c_pkg;

    typedef logic [15:0] phase_t;       // scl half period phase counter
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] sub_addr_t;
    typedef logic [7:0]  byte_count_t;  // 1 to 255 bytes per transaction

    // i_clk cycles per scl half period, 100 MHz in and 400 kHz out
    localparam phase_t SCL_HALF_PERIOD = 16'd125;
    localparam phase_t START_SETUP     = 16'd70;   // start/restart point, also rx sample point
    localparam phase_t DATA_HOLD       = 16'd3;    // sda may change this long after scl falls
    localparam phase_t STOP_SETUP      = 16'd60;   // stop point after scl rises
    localparam phase_t RELEASE_POINT   = SCL_HALF_PERIOD - 16'd3;

    typedef enum logic [3:0] {
        IDLE,
        START,
        RESTART,
        SLAVE_ADDR,
        SUB_ADDR_HI,
        SUB_ADDR_LO,
        WRITE_DATA,
        GRAB_DATA,
        READ_DATA,
        STOP,
        RELEASE_BUS
    } i2c_state_e;

    typedef enum logic [1:0] {
        OP_NONE,
        OP_TX_BYTE,    // shift a byte out, then sample the slave ack
        OP_RX_BYTE     // shift a byte in, then drive the master ack/nack
    } byte_op_e;

endpackage

// ==== rtl/i2c_scl_gen.sv ====
`timescale 1ns/100ps
module i2c_scl_gen (
    input  logic            i_clk,
    input  logic            reset_n,
    input  logic            scl_en_i,
    output logic            scl_o,
    output i2c_pkg::phase_t phase_o,
    output logic            start_point_o,
    output logic            hold_point_o,
    output logic            stop_point_o,
    output logic            release_point_o
);
    import i2c_pkg::*;

    // scl divider, idles high with the counter parked at zero
    always_ff @(posedge i_clk or negedge reset_n) begin
        if (!reset_n) begin
            phase_o <= '0;
            scl_o   <= 1'b1;
        end else if (!scl_en_i) begin
            phase_o <= '0;                          // held until the fsm enables the bus clock
            scl_o   <= 1'b1;
        end else if (phase_o == SCL_HALF_PERIOD - 16'd1) begin
            phase_o <= '0;                          // end of half period
            scl_o   <= ~scl_o;
        end else begin
            phase_o <= phase_o + 16'd1;
        end
    end

    // strobes fire in both halves, users qualify them with the scl level
    assign start_point_o   = scl_en_i && (phase_o == START_SETUP);
    assign hold_point_o    = scl_en_i && (phase_o == DATA_HOLD);
    assign stop_point_o    = scl_en_i && (phase_o == STOP_SETUP);
    assign release_point_o = scl_en_i && (phase_o == RELEASE_POINT);

endmodule

// ==== testbench/i2c_slave_model.sv ====
`timescale 1ns/100ps
module i2c_slave_model (
    input  logic       reset_n,
    input  logic [6:0] dev_addr_i,
    input  logic       wide_sub_i,      // two sub-address bytes follow the address
    input  wire        scl_i,           // no clock stretching, scl is only watched
    inout  wire        sda_o,
    output int         start_cnt_o,
    output int         restart_cnt_o,
    output int         stop_cnt_o,
    output int         ack_cnt_o,       // master acks seen on read bytes
    output int         nack_cnt_o,
    output logic       proto_err_o
);
    import i2c_pkg::*;

    byte_t      mem [0:255];
    byte_t      shreg;
    byte_t      ptr;                    // low sub-address byte, auto-increments
    logic [3:0] rise_cnt;               // scl rises since the byte began, 9 is the ack clock
    int         byte_idx;               // 0 is the address byte
    logic       selected;
    logic       reading;                // addressed with the r/w bit set
    logic       sending;                // slave shifts data out
    logic       master_ack;
    logic       sda_low;

    assign sda_o = sda_low ? 1'b0 : 1'bz;   // open drain, pull-up in the testbench

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = byte_t'(i) ^ 8'h5a;    // background pattern
        end
        start_cnt_o   = 0;
        restart_cnt_o = 0;
        stop_cnt_o    = 0;
        ack_cnt_o     = 0;
        nack_cnt_o    = 0;
        proto_err_o   = 1'b0;
        ptr           = '0;
        shreg         = '0;
        master_ack    = 1'b0;
        end_frame();
    end

    task automatic end_frame();
        selected = 1'b0;
        reading  = 1'b0;
        sending  = 1'b0;
        sda_low  = 1'b0;
        rise_cnt = 4'd0;
        byte_idx = 0;
    endtask

    // framing edges belong to the first scl high of a byte or to an idle bus
    task automatic check_framing();
        assert (rise_cnt < 4'd2 || rise_cnt > 4'd8) else begin
            $display("ERROR: %0t ns: sda changed while scl was high inside a byte", $time);
            proto_err_o = 1'b1;
        end
    endtask

    task automatic take_byte();
        int last_sub;                   // byte index of the low sub-address byte
        last_sub = wide_sub_i ? 2 : 1;
        if (byte_idx == 0) begin
            selected = (shreg[7:1] == dev_addr_i);
            reading  = shreg[0];
        end else if (selected && byte_idx == last_sub) begin
            ptr = shreg;                // high byte is not decoded
        end else if (selected && byte_idx > last_sub) begin
            mem[ptr] = shreg;
            ptr      = ptr + 8'd1;
        end
        sda_low = selected;             // ack only when addressed
    endtask

    // start or repeated start
    always @(negedge sda_o) begin
        if (reset_n === 1'b1 && scl_i === 1'b1) begin
            check_framing();
            if (selected) restart_cnt_o++;
            else start_cnt_o++;
            end_frame();
        end
    end

    // stop
    always @(posedge sda_o) begin
        if (reset_n === 1'b1 && scl_i === 1'b1) begin
            check_framing();
            stop_cnt_o++;
            end_frame();
        end
    end

    always @(posedge scl_i) begin
        if (reset_n === 1'b1) begin
            if (sending && rise_cnt == 4'd8) begin
                master_ack = (sda_o == 1'b0);   // ninth clock of a read byte
                if (master_ack) ack_cnt_o++;
                else nack_cnt_o++;
            end else if (!sending && rise_cnt < 4'd8) begin
                shreg = {shreg[6:0], sda_o};    // msb first
            end
            rise_cnt = rise_cnt + 4'd1;
        end
    end

    always @(negedge scl_i) begin
        if (reset_n === 1'b1) begin
            #250;                               // sda moves well inside scl low
            if (rise_cnt == 4'd8 && !sending) begin
                take_byte();
            end else if (rise_cnt == 4'd8) begin
                sda_low = 1'b0;                 // master owns the ack slot
            end else if (rise_cnt == 4'd9) begin
                sda_low  = 1'b0;
                rise_cnt = 4'd0;
                byte_idx++;
                sending  = selected && reading && (!sending || master_ack);
                if (sending) begin
                    shreg   = mem[ptr];
                    ptr     = ptr + 8'd1;
                    sda_low = !shreg[7];
                end
            end else if (sending && rise_cnt != 4'd0) begin
                sda_low = !shreg[3'd7 - rise_cnt[2:0]];
            end
        end
    end

endmodule

// ==== testbench/tb_i2c_master.sv ====
`timescale 1ns/100ps
module tb_i2c_master;
    import i2c_pkg::*;

    localparam int timeout_cycles = 200000;     // about four times the whole test sequence

    logic        i_clk;
    logic        reset_n;
    logic        req_trans;
    byte_t       addr_rw;
    sub_addr_t   sub_addr;
    logic        sub_len;
    byte_count_t byte_len;
    byte_t       data_write;
    byte_t       data_out;
    logic        valid_out;
    logic        req_data_chunk;
    logic        busy;
    logic        nack;
    wire         scl_line;
    wire         sda_line;
    logic        wide_sub;
    logic        proto_err;
    int          start_cnt, restart_cnt, stop_cnt, ack_cnt, nack_cnt;
    int          base_start, base_restart, base_stop, base_ack, base_nack;
    int          seed;
    int          cycle_cnt = 0;
    int          chunk_cnt;
    int          valid_cnt;
    byte_t       wr_buf [0:7];
    byte_t       rd_buf [0:7];
    byte_t       exp_mem [0:255];               // expected slave memory contents

    pullup (scl_line);
    pullup (sda_line);

    i2c_master uut (
        .i_clk(i_clk), .reset_n(reset_n), .req_trans_i(req_trans), .addr_rw_i(addr_rw),
        .sub_addr_i(sub_addr), .sub_len_i(sub_len), .byte_len_i(byte_len),
        .data_write_i(data_write), .data_out_o(data_out), .valid_out_o(valid_out),
        .req_data_chunk_o(req_data_chunk), .busy_o(busy), .nack_o(nack),
        .scl_o(scl_line), .sda_o(sda_line)
    );

    i2c_slave_model slave (
        .reset_n(reset_n), .dev_addr_i(7'h50), .wide_sub_i(wide_sub), .scl_i(scl_line),
        .sda_o(sda_line), .start_cnt_o(start_cnt), .restart_cnt_o(restart_cnt),
        .stop_cnt_o(stop_cnt), .ack_cnt_o(ack_cnt), .nack_cnt_o(nack_cnt),
        .proto_err_o(proto_err)
    );

    initial begin
        i_clk = 1'b0;
        forever #50 i_clk = ~i_clk;             // 10 MHz
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    always @(posedge i_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_cycles)
            stop_run($sformatf("run timed out after %0d clock cycles", cycle_cnt));
    end

    always @(posedge proto_err) stop_run("slave model saw an illegal sda change on the bus");

    task automatic check_value(input int got, input int exp, input string what);
        assert (got == exp) else
            stop_run($sformatf("ERROR: %0t ns: %s is 0x%0h, expected 0x%0h",
                               $time, what, got, exp));
    endtask

    task automatic next_cycle();
        @(posedge i_clk);
        #10;                                    // drive and sample clear of the edge
    endtask

    task automatic take_counts();
        base_start   = start_cnt;
        base_restart = restart_cnt;
        base_stop    = stop_cnt;
        base_ack     = ack_cnt;
        base_nack    = nack_cnt;
    endtask

    // one request, then serve chunk requests and collect read bytes until busy_o drops
    task automatic run_transaction(input byte_t addr, input sub_addr_t sub, input logic wide,
                                   input byte_count_t len, input logic poke_busy);
        int waited;
        waited     = 0;
        chunk_cnt  = 0;
        valid_cnt  = 0;
        addr_rw    = addr;
        sub_addr   = sub;
        sub_len    = wide;
        wide_sub   = wide;
        byte_len   = len;
        data_write = wr_buf[0];                 // first write byte rides with the request
        req_trans  = 1'b1;
        next_cycle();
        req_trans  = 1'b0;
        check_value(busy, 1, "busy_o after the request");
        check_value(nack, 0, "nack_o after an accepted request");
        while (busy) begin
            next_cycle();
            waited++;
            req_trans = poke_busy && (waited == 300);   // must be ignored while busy
            if (req_data_chunk) begin
                chunk_cnt++;
                data_write = wr_buf[chunk_cnt % 8];
            end
            if (valid_out) begin
                if (valid_cnt < 8) rd_buf[valid_cnt] = data_out;
                valid_cnt++;
            end
        end
    endtask

    initial begin
        seed       = 55510;
        reset_n    = 1'b0;
        req_trans  = 1'b0;
        addr_rw    = '0;
        sub_addr   = '0;
        sub_len    = 1'b0;
        byte_len   = '0;
        data_write = '0;
        wide_sub   = 1'b0;
        repeat (3) @(posedge i_clk);
        #10 reset_n = 1'b1;
        next_cycle();

        check_value(busy, 0, "busy_o after reset");
        check_value(valid_out, 0, "valid_out_o after reset");
        check_value(req_data_chunk, 0, "req_data_chunk_o after reset");
        check_value(nack, 0, "nack_o after reset");
        check_value(scl_line, 1, "scl line after reset");
        check_value(sda_line, 1, "sda line after reset");

        // 3 byte write, 16 bit sub-address, with a stray request while busy
        for (int i = 0; i < 3; i++) wr_buf[i] = $random(seed);
        take_counts();
        run_transaction({7'h50, 1'b0}, 16'h1234, 1'b1, 8'd3, 1'b1);
        for (int i = 0; i < 3; i++)
            check_value(slave.mem[8'h34 + i], wr_buf[i], "slave memory after the write");
        check_value(chunk_cnt, 2, "req_data_chunk_o pulses");
        check_value(start_cnt - base_start, 1, "STARTs seen for the write");
        check_value(stop_cnt - base_stop, 1, "STOPs seen for the write");
        check_value(nack, 0, "nack_o after the write");
        repeat (2 * SCL_HALF_PERIOD) next_cycle();  // a queued request would have sent START
        check_value(busy, 0, "busy_o after the stray request");
        check_value(start_cnt - base_start, 1, "STARTs after the stray request");

        // 4 byte read, 8 bit sub-address, from randomized memory
        for (int i = 0; i < 256; i++) begin
            exp_mem[i]   = $random(seed);
            slave.mem[i] = exp_mem[i];
        end
        take_counts();
        run_transaction({7'h50, 1'b1}, 16'h0080, 1'b0, 8'd4, 1'b0);
        check_value(valid_cnt, 4, "valid_out_o pulses");
        for (int i = 0; i < 4; i++)
            check_value(rd_buf[i], exp_mem[8'h80 + i], "read byte");
        check_value(chunk_cnt, 0, "req_data_chunk_o pulses on a read");
        check_value(start_cnt - base_start, 1, "STARTs seen for the read");
        check_value(restart_cnt - base_restart, 1, "repeated STARTs seen for the read");
        check_value(ack_cnt - base_ack, 3, "master acks on the read");
        check_value(nack_cnt - base_nack, 1, "master nacks on the read");
        check_value(stop_cnt - base_stop, 1, "STOPs seen for the read");

        // absent slave aborts the transaction
        wr_buf[0] = $random(seed);
        take_counts();
        run_transaction({7'h22, 1'b0}, 16'h0010, 1'b0, 8'd1, 1'b0);
        check_value(nack, 1, "nack_o after the absent address");
        for (int i = 0; i < 256; i++)
            check_value(slave.mem[i], exp_mem[i], "slave memory after the abort");
        check_value(scl_line, 1, "scl line after the abort");
        check_value(sda_line, 1, "sda line after the abort");
        check_value(stop_cnt - base_stop, 0, "STOPs seen for the abort");

        // valid single byte write clears the nack flag
        wr_buf[0] = $random(seed);
        take_counts();
        run_transaction({7'h50, 1'b0}, 16'h0010, 1'b0, 8'd1, 1'b0);
        check_value(slave.mem[8'h10], wr_buf[0], "slave memory after the 1 byte write");
        check_value(chunk_cnt, 0, "req_data_chunk_o pulses on a 1 byte write");
        check_value(nack, 0, "nack_o after the 1 byte write");
        check_value(start_cnt - base_start, 1, "STARTs seen for the 1 byte write");
        check_value(stop_cnt - base_stop, 1, "STOPs seen for the 1 byte write");

        repeat (10) next_cycle();
        $display("Testbench passed");
        $finish;
    end

endmodule
